// ==== build.f ====
+incdir+hw
hw/rv_pkg.sv
hw/rv_control.sv
hw/rv_fetch.sv
hw/rv_decode.sv
hw/rv_execute.sv
hw/rv_core.sv
verification/rv_core_sva.sv
verification/rv_core_tb.sv

// ==== hw/rv_control.sv ====
`timescale 1ns/10ps
`include "rv_defines.svh"

module rv_control (
    input  logic           clk,
    input  logic           rst,
    input  rv_pkg::instr_u instr,
    output rv_pkg::ctrl_t  ctrl
);

    rv_pkg::stage_e stage;
    rv_pkg::stage_e stage_next;
    logic           run;
    logic           writes_rd;
    logic           is_store;

    //////////////////////////////////////////////////////////////////////
    // stage sequencer

    // first cycle out of reset is idle, then fetch starts
    always_comb begin
        case (stage)
            rv_pkg::stage_fetch:
                stage_next = run ? rv_pkg::stage_decode : rv_pkg::stage_fetch;
            rv_pkg::stage_decode:    stage_next = rv_pkg::stage_execute;
            rv_pkg::stage_execute:   stage_next = rv_pkg::stage_memory;
            rv_pkg::stage_memory:    stage_next = rv_pkg::stage_writeback;
            default:                 stage_next = rv_pkg::stage_fetch;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            stage <= rv_pkg::stage_fetch;
            run   <= 1'b0;
        end else begin
            stage <= stage_next;
            run   <= 1'b1;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // instruction decode and strobes

    always_comb begin
        ctrl      = '0;
        writes_rd = 1'b0;
        is_store  = 1'b0;
        ctrl.imm_sel = rv_pkg::imm_i;
        ctrl.res_sel = rv_pkg::res_alu;

        case (instr.r_type.opcode)
            `OP_OP: begin
                writes_rd    = 1'b1;
                ctrl.alu_sub = instr.r_type.funct7[5];
            end
            `OP_IMM: writes_rd = 1'b1;
            `OP_LOAD: begin
                writes_rd     = 1'b1;
                ctrl.sel_load = 1'b1;
            end
            `OP_STORE: begin
                is_store     = 1'b1;
                ctrl.imm_sel = rv_pkg::imm_s;
            end
            `OP_BRANCH: begin
                ctrl.is_branch = 1'b1;
                // beq is funct3 000, bne is 001
                ctrl.branch_ne = instr.b_type.funct3[0];
                ctrl.imm_sel   = rv_pkg::imm_b;
            end
            `OP_LUI: begin
                writes_rd    = 1'b1;
                ctrl.imm_sel = rv_pkg::imm_u;
                ctrl.res_sel = rv_pkg::res_imm;
            end
            `OP_JAL: begin
                writes_rd      = 1'b1;
                ctrl.take_jump = 1'b1;
                ctrl.imm_sel   = rv_pkg::imm_j;
                ctrl.res_sel   = rv_pkg::res_link;
            end
            default: ;
        endcase

        ctrl.ld_ir  = run && (stage == rv_pkg::stage_fetch);
        ctrl.ld_ops = (stage == rv_pkg::stage_decode);
        ctrl.ld_pc  = (stage == rv_pkg::stage_decode);
        ctrl.ld_ex  = (stage == rv_pkg::stage_execute);
        ctrl.ld_me  = (stage == rv_pkg::stage_memory);
        ctrl.mem_we = is_store && (stage == rv_pkg::stage_memory);
        ctrl.rf_we  = writes_rd && (stage == rv_pkg::stage_writeback);
    end

endmodule

// ==== hw/rv_core.sv ====
`timescale 1ns/10ps
`include "rv_defines.svh"

module rv_core (
    input  logic              clk,
    input  logic              rst,
    output logic [`XLEN-1:0]  imem_addr,
    input  logic [`XLEN-1:0]  imem_data,
    output logic [`XLEN-1:0]  dmem_addr,
    output logic [`XLEN-1:0]  dmem_wdata,
    output logic              dmem_we,
    input  logic [`XLEN-1:0]  dmem_rdata
);

    rv_pkg::ctrl_t           ctrl;
    rv_pkg::instr_u          instr;
    logic [`XLEN-1:0]        next_pc;
    logic [`XLEN-1:0]        jump_target;
    logic                    take;
    logic [`XLEN-1:0]        rs1_val;
    logic [`XLEN-1:0]        rs2_val;
    logic [`XLEN-1:0]        imm_val;
    logic [`XLEN-1:0]        wb_data;
    logic [`REG_ADDR_W-1:0]  wb_rd;

    assign dmem_we = ctrl.mem_we;

    rv_control rv_control_inst (
        .clk (clk), .rst (rst), .instr (instr), .ctrl (ctrl)
    );

    rv_fetch rv_fetch_inst (
        .clk (clk), .rst (rst), .ctrl (ctrl), .imem_data (imem_data),
        .jump_target (jump_target), .take (take), .imem_addr (imem_addr),
        .instr (instr), .next_pc (next_pc)
    );

    // pc during decode is still the decoded instruction's own address
    rv_decode rv_decode_inst (
        .clk (clk), .rst (rst), .ctrl (ctrl), .instr (instr), .pc (imem_addr),
        .wb_data (wb_data), .wb_rd (wb_rd), .rs1_val (rs1_val), .rs2_val (rs2_val),
        .imm_val (imm_val), .jump_target (jump_target), .take (take)
    );

    rv_execute rv_execute_inst (
        .clk (clk), .rst (rst), .ctrl (ctrl), .instr (instr), .rs1_val (rs1_val),
        .rs2_val (rs2_val), .imm_val (imm_val), .link (next_pc),
        .dmem_rdata (dmem_rdata), .dmem_addr (dmem_addr), .dmem_wdata (dmem_wdata),
        .wb_data (wb_data), .wb_rd (wb_rd)
    );

endmodule

// ==== hw/rv_decode.sv ====
`timescale 1ns/10ps
`include "rv_defines.svh"

module rv_decode (
    input  logic                    clk,
    input  logic                    rst,
    input  rv_pkg::ctrl_t           ctrl,
    input  rv_pkg::instr_u          instr,
    input  logic [`XLEN-1:0]        pc,
    input  logic [`XLEN-1:0]        wb_data,
    input  logic [`REG_ADDR_W-1:0]  wb_rd,
    output logic [`XLEN-1:0]        rs1_val,
    output logic [`XLEN-1:0]        rs2_val,
    output logic [`XLEN-1:0]        imm_val,
    output logic [`XLEN-1:0]        jump_target,
    output logic                    take
);

    logic [`XLEN-1:0] rf [`REG_COUNT];
    logic [`XLEN-1:0] rf_rs1;
    logic [`XLEN-1:0] rf_rs2;
    logic [`XLEN-1:0] imm;
    logic             rs_equal;

    //////////////////////////////////////////////////////////////////////
    // register file

    always_ff @(posedge clk) begin
        if (ctrl.rf_we && wb_rd != '0) begin
            rf[wb_rd] <= wb_data;
        end
    end

    // x0 reads zero
    assign rf_rs1 = (instr.r_type.rs1 == '0) ? '0 : rf[instr.r_type.rs1];
    assign rf_rs2 = (instr.r_type.rs2 == '0) ? '0 : rf[instr.r_type.rs2];

    //////////////////////////////////////////////////////////////////////
    // immediate generation

    always_comb begin
        case (ctrl.imm_sel)
            rv_pkg::imm_i: imm = {{20{instr.i_type.imm[11]}}, instr.i_type.imm};
            rv_pkg::imm_s: imm = {{20{instr.s_type.imm_hi[6]}},
                                  instr.s_type.imm_hi, instr.s_type.imm_lo};
            rv_pkg::imm_b: imm = {{19{instr.b_type.imm_12}}, instr.b_type.imm_12,
                                  instr.b_type.imm_11, instr.b_type.imm_10_5,
                                  instr.b_type.imm_4_1, 1'b0};
            rv_pkg::imm_u: imm = {instr.u_type.imm, 12'b0};
            rv_pkg::imm_j: imm = {{11{instr.j_type.imm_20}}, instr.j_type.imm_20,
                                  instr.j_type.imm_19_12, instr.j_type.imm_11,
                                  instr.j_type.imm_10_1, 1'b0};
            default:       imm = '0;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // branch unit

    assign rs_equal    = (rf_rs1 == rf_rs2);
    assign take        = ctrl.take_jump || (ctrl.is_branch && (rs_equal ^ ctrl.branch_ne));
    // offset counts words
    assign jump_target = pc + imm;

    // operand registers
    always_ff @(posedge clk) begin
        if (ctrl.ld_ops) begin
            rs1_val <= rf_rs1;
            rs2_val <= rf_rs2;
            imm_val <= imm;
        end
    end

endmodule

// ==== hw/rv_defines.svh ====
`ifndef RV_DEFINES_SVH
`define RV_DEFINES_SVH

// datapath sizes
`define XLEN        32
`define REG_COUNT   32
`define REG_ADDR_W  5

// supported major opcodes
`define OP_OP       7'b0110011
`define OP_IMM      7'b0010011
`define OP_LOAD     7'b0000011
`define OP_STORE    7'b0100011
`define OP_BRANCH   7'b1100011
`define OP_LUI      7'b0110111
`define OP_JAL      7'b1101111

`endif

// ==== hw/rv_execute.sv ====
`timescale 1ns/10ps
`include "rv_defines.svh"

module rv_execute (
    input  logic                    clk,
    input  logic                    rst,
    input  rv_pkg::ctrl_t           ctrl,
    input  rv_pkg::instr_u          instr,
    input  logic [`XLEN-1:0]        rs1_val,
    input  logic [`XLEN-1:0]        rs2_val,
    input  logic [`XLEN-1:0]        imm_val,
    input  logic [`XLEN-1:0]        link,
    input  logic [`XLEN-1:0]        dmem_rdata,
    output logic [`XLEN-1:0]        dmem_addr,
    output logic [`XLEN-1:0]        dmem_wdata,
    output logic [`XLEN-1:0]        wb_data,
    output logic [`REG_ADDR_W-1:0]  wb_rd
);

    logic [`XLEN-1:0] alu_b;
    logic [`XLEN-1:0] alu_out;
    logic [`XLEN-1:0] result;
    logic [`XLEN-1:0] ex_result;

    // register-register ops take rs2, the rest the immediate
    assign alu_b   = (instr.r_type.opcode == `OP_OP) ? rs2_val : imm_val;
    assign alu_out = ctrl.alu_sub ? rs1_val - alu_b : rs1_val + alu_b;

    always_comb begin
        case (ctrl.res_sel)
            rv_pkg::res_link: result = link;
            rv_pkg::res_imm:  result = imm_val;
            default:          result = alu_out;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // execute stage registers

    always_ff @(posedge clk) begin
        if (ctrl.ld_ex) begin
            ex_result  <= result;
            dmem_addr  <= rs1_val + imm_val;
            dmem_wdata <= rs2_val;
            wb_rd      <= instr.r_type.rd;
        end
    end

    // memory stage result
    always_ff @(posedge clk) begin
        if (ctrl.ld_me) begin
            wb_data <= ctrl.sel_load ? dmem_rdata : ex_result;
        end
    end

endmodule

// ==== hw/rv_fetch.sv ====
`timescale 1ns/10ps
`include "rv_defines.svh"

module rv_fetch (
    input  logic              clk,
    input  logic              rst,
    input  rv_pkg::ctrl_t     ctrl,
    input  logic [`XLEN-1:0]  imem_data,
    input  logic [`XLEN-1:0]  jump_target,
    input  logic              take,
    output logic [`XLEN-1:0]  imem_addr,
    output rv_pkg::instr_u    instr,
    output logic [`XLEN-1:0]  next_pc
);

    logic [`XLEN-1:0] pc;

    assign imem_addr = pc;

    // word addressed, sequential step is one
    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= '0;
        end else if (ctrl.ld_pc) begin
            pc <= take ? jump_target : next_pc;
        end
    end

    // ir cleared so control sees a no-op before the first fetch
    always_ff @(posedge clk) begin
        if (rst) begin
            instr <= '0;
        end else if (ctrl.ld_ir) begin
            instr <= imem_data;
        end
    end

    // held until execute for the jal link
    always_ff @(posedge clk) begin
        if (ctrl.ld_ir) begin
            next_pc <= pc + 1'b1;
        end
    end

endmodule

// ==== hw/rv_pkg.sv ====
package rv_pkg;

    //////////////////////////////////////////////////////////////////////
    // instruction formats, fields in encoding order

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_type_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_type_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_type_t;

    typedef struct packed {
        logic [19:0] imm;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_type_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_type_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_type_t;

    typedef union packed {
        r_type_t r_type;
        i_type_t i_type;
        s_type_t s_type;
        u_type_t u_type;
        b_type_t b_type;
        j_type_t j_type;
    } instr_u;

    //////////////////////////////////////////////////////////////////////
    // control

    typedef enum logic [2:0] {
        stage_fetch,
        stage_decode,
        stage_execute,
        stage_memory,
        stage_writeback
    } stage_e;

    typedef enum logic [2:0] {
        imm_i,
        imm_s,
        imm_b,
        imm_u,
        imm_j
    } imm_sel_e;

    typedef enum logic [1:0] {
        res_alu,
        res_link,
        res_imm
    } res_sel_e;

    typedef struct packed {
        logic     ld_pc;
        logic     ld_ir;
        logic     ld_ops;
        logic     ld_ex;
        logic     ld_me;
        logic     rf_we;
        logic     take_jump;
        logic     is_branch;
        logic     branch_ne;
        imm_sel_e imm_sel;
        logic     alu_sub;
        res_sel_e res_sel;
        logic     sel_load;
        logic     mem_we;
    } ctrl_t;

endpackage

// ==== verification/rv_core_sva.sv ====
`timescale 1ns/10ps

module rv_core_sva (
    input logic           clk,
    input logic           rst,
    input rv_pkg::stage_e stage,
    input logic           run,
    input rv_pkg::ctrl_t  ctrl
);

    logic [6:0] strobes;

    assign strobes = {ctrl.ld_pc, ctrl.ld_ir, ctrl.ld_ops, ctrl.ld_ex,
                      ctrl.ld_me, ctrl.rf_we, ctrl.mem_we};

    //////////////////////////////////////////////////////////////////////
    // stage sequencing

    fetch_to_decode: assert property (@(posedge clk) disable iff (rst)
        (stage == rv_pkg::stage_fetch && run) |=> stage == rv_pkg::stage_decode)
        else $error("fetch was not followed by decode");

    // decode, execute and memory each step to the next stage
    middle_stages: assert property (@(posedge clk) disable iff (rst)
        (stage inside {rv_pkg::stage_decode, rv_pkg::stage_execute, rv_pkg::stage_memory})
        |=> stage == rv_pkg::stage_e'($past(stage) + 3'd1))
        else $error("stage did not advance in order");

    writeback_to_fetch: assert property (@(posedge clk) disable iff (rst)
        stage == rv_pkg::stage_writeback |=> stage == rv_pkg::stage_fetch)
        else $error("writeback was not followed by fetch");

    //////////////////////////////////////////////////////////////////////
    // strobes

    mem_we_in_memory: assert property (@(posedge clk) disable iff (rst)
        ctrl.mem_we |-> stage == rv_pkg::stage_memory)
        else $error("mem_we outside the memory stage");

    ld_pc_in_decode: assert property (@(posedge clk) disable iff (rst)
        ctrl.ld_pc |-> stage == rv_pkg::stage_decode)
        else $error("ld_pc outside the decode stage");

    quiet_after_reset: assert property (@(posedge clk)
        rst |=> strobes == '0)
        else $error("strobe active right after reset");

endmodule

bind rv_control rv_core_sva rv_core_sva_inst (
    .clk (clk), .rst (rst), .stage (stage), .run (run), .ctrl (ctrl)
);

// ==== verification/rv_core_tb.sv ====
`timescale 1ns/10ps
`include "rv_defines.svh"

module rv_core_tb;

    localparam int total_instr     = 40;
    localparam int test_count      = 6;
    localparam int watchdog_cycles = total_instr * 5 + test_count * 10 + 100;

    logic             clk;
    logic             rst;
    logic [`XLEN-1:0] imem_addr;
    logic [`XLEN-1:0] imem_data;
    logic [`XLEN-1:0] dmem_addr;
    logic [`XLEN-1:0] dmem_wdata;
    logic [`XLEN-1:0] dmem_rdata;
    logic             dmem_we;

    logic [`XLEN-1:0] imem [256];
    logic [`XLEN-1:0] dmem [256];
    logic [`XLEN-1:0] st_addr [$];
    logic [`XLEN-1:0] st_data [$];
    logic [`XLEN-1:0] pc_trace [$];
    logic [`XLEN-1:0] exp_addr [$];
    logic [`XLEN-1:0] exp_data [$];
    logic [`XLEN-1:0] exp_pc [$];
    logic [31:0]      lfsr_state;
    int               error_count;
    int               check_count;

    rv_core rv_core_inst (
        .clk (clk), .rst (rst), .imem_addr (imem_addr), .imem_data (imem_data),
        .dmem_addr (dmem_addr), .dmem_wdata (dmem_wdata), .dmem_we (dmem_we),
        .dmem_rdata (dmem_rdata)
    );

    //////////////////////////////////////////////////////////////////////
    // clock and memory models

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    assign imem_data  = imem[imem_addr[7:0]];
    assign dmem_rdata = dmem[dmem_addr[7:0]];

    always @(posedge clk) begin
        if (dmem_we) begin
            dmem[dmem_addr[7:0]] <= dmem_wdata;
        end
    end

    // store monitor
    always @(negedge clk) begin
        if (dmem_we === 1'b1) begin
            st_addr.push_back(dmem_addr);
            st_data.push_back(dmem_wdata);
        end
    end

    //////////////////////////////////////////////////////////////////////
    // instruction encoders

    function automatic logic [31:0] r_format(input logic [6:0] f7, input logic [4:0] rs2,
                                             input logic [4:0] rs1, input logic [4:0] rd);
        return {f7, rs2, rs1, 3'b000, rd, `OP_OP};
    endfunction

    function automatic logic [31:0] i_format(input logic [6:0] op, input logic [2:0] f3,
                                             input logic [11:0] imm, input logic [4:0] rs1,
                                             input logic [4:0] rd);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] s_format(input logic [11:0] imm, input logic [4:0] rs2,
                                             input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], `OP_STORE};
    endfunction

    function automatic logic [31:0] b_format(input logic [12:0] imm, input logic [4:0] rs2,
                                             input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], `OP_BRANCH};
    endfunction

    function automatic logic [31:0] u_format(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, `OP_LUI};
    endfunction

    function automatic logic [31:0] j_format(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, `OP_JAL};
    endfunction

    // galois form, taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [11:0] random_imm12();
        logic [11:0] v;
        v = '0;
        for (int i = 0; i < 12; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[10:0], lfsr_state[0]};
        end
        return v;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // helpers

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("error %s: expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic fill_memories();
        for (int i = 0; i < 256; i++) begin
            // addi x0 with the address as immediate
            imem[i] = i_format(`OP_IMM, 3'b000, 12'(i), 5'd0, 5'd0);
            dmem[i] = 32'h5a00_0000 | (i << 12) | i;
        end
    endtask

    task automatic apply_reset();
        @(posedge clk);
        rst <= 1'b1;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        st_addr.delete();
        st_data.delete();
        pc_trace.delete();
    endtask

    // one idle cycle after reset, then five cycles per instruction
    task automatic execute_program(input int count);
        @(posedge clk);
        repeat (count) begin
            @(negedge clk);
            pc_trace.push_back(imem_addr);
            repeat (5) @(posedge clk);
        end
    endtask

    task automatic expect_store(input logic [31:0] addr, input logic [31:0] data);
        exp_addr.push_back(addr);
        exp_data.push_back(data);
    endtask

    task automatic expect_pcs_from_zero(input int count);
        for (int i = 0; i < count; i++) begin
            exp_pc.push_back(i);
        end
    endtask

    task automatic compare_results(input string name);
        check_value($sformatf("%s store count", name), exp_addr.size(), st_addr.size());
        for (int i = 0; i < exp_addr.size() && i < st_addr.size(); i++) begin
            check_value($sformatf("%s store %0d addr", name, i), exp_addr[i], st_addr[i]);
            check_value($sformatf("%s store %0d data", name, i), exp_data[i], st_data[i]);
        end
        check_value($sformatf("%s pc count", name), exp_pc.size(), pc_trace.size());
        for (int i = 0; i < exp_pc.size() && i < pc_trace.size(); i++) begin
            check_value($sformatf("%s pc %0d", name, i), exp_pc[i], pc_trace[i]);
        end
        exp_addr.delete();
        exp_data.delete();
        exp_pc.delete();
    endtask

    //////////////////////////////////////////////////////////////////////
    // directed tests

    task automatic reset_behavior();
        fill_memories();
        imem[0] = s_format(12'd5, 5'd0, 5'd0);
        apply_reset();
        for (int c = 0; c < 4; c++) begin
            @(negedge clk);
            check_value($sformatf("reset cycle %0d dmem_we", c), 32'd0, 32'(dmem_we));
            if (c == 0) begin
                check_value("reset imem_addr", 32'd0, imem_addr);
            end
        end
        repeat (3) @(posedge clk);
        expect_store(32'd5, 32'd0);
        compare_results("reset");
    endtask

    task automatic arith_ops();
        int a;
        int b;
        a = 123;
        b = -45;
        fill_memories();
        imem[0] = i_format(`OP_IMM, 3'b000, 12'(a), 5'd0, 5'd1);
        imem[1] = i_format(`OP_IMM, 3'b000, 12'(b), 5'd0, 5'd2);
        imem[2] = r_format(7'h00, 5'd2, 5'd1, 5'd3);
        imem[3] = r_format(7'h20, 5'd2, 5'd1, 5'd4);
        imem[4] = i_format(`OP_IMM, 3'b000, 12'd7, 5'd1, 5'd0);
        imem[5] = s_format(12'd16, 5'd3, 5'd0);
        imem[6] = s_format(12'd3, 5'd4, 5'd1);
        imem[7] = r_format(7'h00, 5'd0, 5'd0, 5'd5);
        imem[8] = s_format(12'd20, 5'd5, 5'd1);
        apply_reset();
        execute_program(9);
        expect_store(16, a + b);
        expect_store(a + 3, a - b);
        expect_store(a + 20, 32'd0);
        expect_pcs_from_zero(9);
        compare_results("arith");
    endtask

    task automatic load_use();
        fill_memories();
        dmem[40] = 32'h1234_5678;
        imem[0] = i_format(`OP_IMM, 3'b000, 12'd30, 5'd0, 5'd6);
        imem[1] = i_format(`OP_LOAD, 3'b010, 12'd10, 5'd6, 5'd7);
        imem[2] = i_format(`OP_IMM, 3'b000, 12'd99, 5'd0, 5'd8);
        imem[3] = r_format(7'h00, 5'd8, 5'd7, 5'd9);
        imem[4] = s_format(12'd1, 5'd9, 5'd6);
        apply_reset();
        execute_program(5);
        expect_store(32'd31, 32'h1234_5678 + 32'd99);
        expect_pcs_from_zero(5);
        compare_results("load");
    endtask

    task automatic branch_paths();
        int path [11];
        path = '{0, 1, 2, 3, 7, 8, 9, 10, 11, 12, 16};
        fill_memories();
        imem[0]  = i_format(`OP_IMM, 3'b000, 12'd5, 5'd0, 5'd1);
        imem[1]  = i_format(`OP_IMM, 3'b000, 12'd5, 5'd0, 5'd2);
        imem[2]  = i_format(`OP_IMM, 3'b000, 12'd9, 5'd0, 5'd3);
        imem[3]  = b_format(13'd4, 5'd2, 5'd1, 3'b000);
        imem[4]  = s_format(12'd50, 5'd1, 5'd0);
        imem[7]  = s_format(12'd51, 5'd2, 5'd0);
        imem[8]  = b_format(13'd4, 5'd2, 5'd1, 3'b001);
        imem[9]  = s_format(12'd52, 5'd3, 5'd0);
        imem[10] = b_format(13'd4, 5'd3, 5'd1, 3'b000);
        imem[11] = s_format(12'd53, 5'd1, 5'd0);
        imem[12] = b_format(13'd4, 5'd3, 5'd1, 3'b001);
        imem[13] = s_format(12'd54, 5'd3, 5'd0);
        imem[16] = s_format(12'd55, 5'd3, 5'd0);
        apply_reset();
        execute_program(11);
        expect_store(32'd51, 32'd5);
        expect_store(32'd52, 32'd9);
        expect_store(32'd53, 32'd5);
        expect_store(32'd55, 32'd9);
        foreach (path[i]) begin
            exp_pc.push_back(path[i]);
        end
        compare_results("branch");
    endtask

    task automatic lui_jal();
        logic [19:0] upper;
        int          jal_pc;
        upper  = 20'habcde;
        jal_pc = 1;
        fill_memories();
        imem[0] = u_format(upper, 5'd10);
        imem[1] = j_format(21'd6, 5'd11);
        imem[2] = s_format(12'd60, 5'd10, 5'd0);
        imem[7] = s_format(12'd61, 5'd11, 5'd0);
        imem[8] = s_format(12'd62, 5'd10, 5'd0);
        apply_reset();
        execute_program(4);
        expect_store(32'd61, jal_pc + 1);
        expect_store(32'd62, 32'(upper) << 12);
        exp_pc.push_back(32'd0);
        exp_pc.push_back(32'd1);
        exp_pc.push_back(32'd7);
        exp_pc.push_back(32'd8);
        compare_results("lui_jal");
    endtask

    task automatic random_accumulate();
        logic [11:0] imm;
        logic [31:0] sum;
        sum = '0;
        fill_memories();
        for (int k = 0; k < 8; k++) begin
            imm = random_imm12();
            imem[k] = i_format(`OP_IMM, 3'b000, imm, (k == 0) ? 5'd0 : 5'd12, 5'd12);
            sum = sum + 32'($signed(imm));
        end
        imem[8] = s_format(12'd70, 5'd12, 5'd0);
        apply_reset();
        execute_program(9);
        expect_store(32'd70, sum);
        expect_pcs_from_zero(9);
        compare_results("random");
    endtask

    //////////////////////////////////////////////////////////////////////
    // main sequence and watchdog

    initial begin
        rst         = 1'b1;
        error_count = 0;
        check_count = 0;
        lfsr_state  = 32'hd74b3c8a;
        fill_memories();
        reset_behavior();
        arith_ops();
        load_use();
        branch_paths();
        lui_jal();
        random_accumulate();
        $display("checks %0d, errors %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    initial begin
        #(watchdog_cycles * 4);
        $display("watchdog timeout, tests did not finish within %0d cycles", watchdog_cycles);
        $display("sim failed");
        $finish;
    end

endmodule
